//--- src/ctrl_settings.svh
`ifndef CTRL_SETTINGS_SVH
`define CTRL_SETTINGS_SVH

// data path and cause widths.
`define CTRL_XLEN       32
`define CTRL_FAST_IRQS  15
`define CTRL_CAUSE_W    6

// a fast line cause is this base plus the line number.
`define CTRL_FAST_BASE  6'h30

// exception codes, with the interrupt flag clear.
`define CTRL_EXC_FETCH_FAULT  5'd1
`define CTRL_EXC_ILLEGAL      5'd2
`define CTRL_EXC_BREAKPOINT   5'd3
`define CTRL_EXC_LOAD_FAULT   5'd5
`define CTRL_EXC_STORE_FAULT  5'd7
`define CTRL_EXC_ECALL_U      5'd8
`define CTRL_EXC_ECALL_M      5'd11

// interrupt codes, with the interrupt flag set.
`define CTRL_IRQ_SOFTWARE  5'd3
`define CTRL_IRQ_TIMER     5'd7
`define CTRL_IRQ_EXTERNAL  5'd11
`define CTRL_IRQ_NM        5'd31

`endif

//--- src/ctrl_pkg.sv
`include "ctrl_settings.svh"

package ctrl_pkg;

	typedef enum logic [1:0] {
		PRIV_LVL_U = 2'b00,
		PRIV_LVL_M = 2'b11
	} priv_lvl_e;

	typedef enum logic [2:0] {
		PC_BOOT = 3'd0,
		PC_JUMP = 3'd1,
		PC_EXC  = 3'd2,
		PC_ERET = 3'd3
	} pc_sel_e;

	typedef enum logic [1:0] {
		EXC_PC_EXC = 2'd0,
		EXC_PC_IRQ = 2'd1
	} exc_pc_sel_e;

	typedef struct packed {
		logic                      irq;
		logic [`CTRL_CAUSE_W-2:0]  code;
	} exc_cause_t;

	// software sits in the top bit, the fast lines in the low bits.
	typedef struct packed {
		logic                        software;
		logic                        timer;
		logic                        external;
		logic [`CTRL_FAST_IRQS-1:0]  fast;
	} irq_vec_t;

	typedef struct packed {
		logic                   valid;
		logic                   illegal;
		logic                   ecall;
		logic                   mret;
		logic                   wfi;
		logic                   ebreak;
		logic                   fetch_err;
		logic                   is_compressed;
		logic [`CTRL_XLEN-1:0]  instr;
		logic [15:0]            instr_c;
		logic [`CTRL_XLEN-1:0]  pc;
	} id_info_t;

	typedef struct packed {
		logic                   load_err;
		logic                   store_err;
		logic [`CTRL_XLEN-1:0]  addr;
	} lsu_err_t;

	typedef struct packed {
		logic                   exc;
		logic                   mret;
		logic                   wfi;
		exc_cause_t             cause;
		logic [`CTRL_XLEN-1:0]  tval;
	} exc_req_t;

	typedef struct packed {
		logic                   save_if;
		logic                   save_id;
		logic                   restore_mret;
		logic                   save_cause;
		exc_cause_t             cause;
		logic [`CTRL_XLEN-1:0]  mtval;
	} csr_ctrl_t;

endpackage

//--- src/ctrl_irq_arbiter.sv
`include "ctrl_settings.svh"

module ctrl_irq_arbiter (
	input  ctrl_pkg::irq_vec_t    irqs_i,
	input  logic                  irq_nm_i,
	input  logic                  csr_mstatus_mie_i,
	input  logic                  nmi_mode_i,
	output logic                  irq_take_o,
	output logic                  irq_wake_o,
	output ctrl_pkg::exc_cause_t  irq_cause_o
);

	localparam int unsigned FAST_ID_W = $clog2(`CTRL_FAST_IRQS);

	logic                  irq_any;
	logic [FAST_ID_W-1:0]  fast_id;

	// the lines arrive already masked by mie, so any set bit is pending.
	assign irq_any    = |irqs_i;
	assign irq_wake_o = irq_any | irq_nm_i;
	assign irq_take_o = ~nmi_mode_i & (irq_nm_i | (irq_any & csr_mstatus_mie_i));

	// the highest numbered fast line wins.
	always_comb begin
		fast_id = '0;
		for (int i = 0; i < `CTRL_FAST_IRQS; i++) begin
			if (irqs_i.fast[i]) begin
				fast_id = FAST_ID_W'(i);
			end
		end
	end

	always_comb begin
		if (irq_nm_i) begin
			irq_cause_o = '{irq: 1'b1, code: `CTRL_IRQ_NM};
		end else if (|irqs_i.fast) begin
			irq_cause_o = ctrl_pkg::exc_cause_t'(`CTRL_FAST_BASE | `CTRL_CAUSE_W'(fast_id));
		end else if (irqs_i.external) begin
			irq_cause_o = '{irq: 1'b1, code: `CTRL_IRQ_EXTERNAL};
		end else if (irqs_i.software) begin
			irq_cause_o = '{irq: 1'b1, code: `CTRL_IRQ_SOFTWARE};
		end else begin
			irq_cause_o = '{irq: 1'b1, code: `CTRL_IRQ_TIMER};
		end
	end

endmodule

//--- src/ctrl_exc_capture.sv
`include "ctrl_settings.svh"

module ctrl_exc_capture (
	input  logic                 clk_i,
	input  logic                 rst_ni,
	input  ctrl_pkg::id_info_t   id_i,
	input  ctrl_pkg::lsu_err_t   lsu_i,
	input  ctrl_pkg::priv_lvl_e  priv_mode_i,
	input  logic                 csr_mstatus_tw_i,
	input  logic                 flush_state_i,
	output logic                 special_req_o,
	output ctrl_pkg::exc_req_t   req_o
);

	logic                   fetch_err;
	logic                   ecall;
	logic                   ebreak;
	logic                   mret_insn;
	logic                   wfi_insn;
	logic                   illegal_umode;
	logic                   illegal;
	logic                   exc;
	ctrl_pkg::exc_cause_t   cause_d;
	logic [`CTRL_XLEN-1:0]  tval_d;
	logic                   exc_q;
	logic                   mret_q;
	logic                   wfi_q;
	ctrl_pkg::exc_cause_t   cause_q;
	logic [`CTRL_XLEN-1:0]  tval_q;

	// ------------------------------
	// decode qualification.
	assign fetch_err = id_i.valid & id_i.fetch_err;
	assign ecall     = id_i.valid & id_i.ecall;
	assign ebreak    = id_i.valid & id_i.ebreak;
	assign mret_insn = id_i.valid & id_i.mret;
	assign wfi_insn  = id_i.valid & id_i.wfi;

	// mret, and wfi under timeout-wait, are machine mode only.
	assign illegal_umode = (priv_mode_i != ctrl_pkg::PRIV_LVL_M) &
		(mret_insn | (csr_mstatus_tw_i & wfi_insn));
	assign illegal = (id_i.valid & id_i.illegal) | illegal_umode;

	assign exc = fetch_err | illegal | ecall | ebreak | lsu_i.load_err | lsu_i.store_err;
	assign special_req_o = exc | mret_insn | wfi_insn;

	// ------------------------------
	// exception priority.
	always_comb begin
		cause_d = '{irq: 1'b0, code: `CTRL_EXC_LOAD_FAULT};
		tval_d  = lsu_i.addr;
		if (fetch_err) begin
			cause_d.code = `CTRL_EXC_FETCH_FAULT;
			tval_d       = id_i.pc;
		end else if (illegal) begin
			cause_d.code = `CTRL_EXC_ILLEGAL;
			tval_d       = id_i.is_compressed ?
				{{(`CTRL_XLEN-16){1'b0}}, id_i.instr_c} : id_i.instr;
		end else if (ecall) begin
			cause_d.code = (priv_mode_i == ctrl_pkg::PRIV_LVL_M) ?
				`CTRL_EXC_ECALL_M : `CTRL_EXC_ECALL_U;
			tval_d       = '0;
		end else if (ebreak) begin
			cause_d.code = `CTRL_EXC_BREAKPOINT;
			tval_d       = '0;
		end else if (lsu_i.store_err) begin
			cause_d.code = `CTRL_EXC_STORE_FAULT;
		end
	end

	// the request is held for the whole flush.
	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			exc_q  <= 1'b0;
			mret_q <= 1'b0;
			wfi_q  <= 1'b0;
		end else if (!flush_state_i) begin
			exc_q  <= exc;
			mret_q <= mret_insn & ~exc;
			wfi_q  <= wfi_insn & ~exc;
		end
	end

	always_ff @(posedge clk_i) begin
		if (!flush_state_i) begin
			cause_q <= cause_d;
			tval_q  <= tval_d;
		end
	end

	assign req_o = '{exc: exc_q, mret: mret_q, wfi: wfi_q, cause: cause_q, tval: tval_q};

	a_one_request: assert property (@(posedge clk_i) disable iff (!rst_ni)
		$onehot0({req_o.exc, req_o.mret, req_o.wfi}));

endmodule

//--- src/ctrl_fsm.sv
`include "ctrl_settings.svh"

module ctrl_fsm (
	input  logic                    clk_i,
	input  logic                    rst_ni,
	input  logic                    fetch_enable_i,
	input  logic                    instr_valid_i,
	input  logic                    stall_i,
	input  logic                    branch_set_i,
	input  logic                    jump_set_i,
	input  logic                    special_req_i,
	input  ctrl_pkg::exc_req_t      req_i,
	input  logic                    irq_take_i,
	input  ctrl_pkg::exc_cause_t    irq_cause_i,
	input  logic                    irq_wake_i,
	output logic                    flush_state_o,
	output logic                    nmi_mode_o,
	output logic                    ctrl_busy_o,
	output logic                    instr_req_o,
	output logic                    id_in_ready_o,
	output logic                    instr_valid_clear_o,
	output logic                    pc_set_o,
	output ctrl_pkg::pc_sel_e       pc_mux_o,
	output ctrl_pkg::exc_pc_sel_e   exc_pc_mux_o,
	output ctrl_pkg::csr_ctrl_t     csr_o
);

	typedef enum logic [2:0] {
		RESET,
		BOOT_SET,
		FIRST_FETCH,
		DECODE,
		FLUSH,
		IRQ_TAKEN,
		WAIT_SLEEP,
		SLEEP
	} state_e;

	state_e  state_q;
	state_e  state_d;
	logic    nmi_mode_q;
	logic    nmi_mode_d;
	logic    halt_if;
	logic    flush_id;

	// ------------------------------
	// next state and outputs.
	always_comb begin
		state_d      = state_q;
		nmi_mode_d   = nmi_mode_q;
		instr_req_o  = 1'b1;
		ctrl_busy_o  = 1'b1;
		halt_if      = 1'b0;
		flush_id     = 1'b0;
		pc_set_o     = 1'b0;
		pc_mux_o     = ctrl_pkg::PC_BOOT;
		exc_pc_mux_o = ctrl_pkg::EXC_PC_IRQ;
		csr_o        = '0;

		case (state_q)
			RESET: begin
				instr_req_o = 1'b0;
				pc_set_o    = 1'b1;
				if (fetch_enable_i) begin
					state_d = BOOT_SET;
				end
			end
			BOOT_SET: begin
				pc_set_o = 1'b1;
				state_d  = FIRST_FETCH;
			end
			FIRST_FETCH: begin
				if (!stall_i) begin
					state_d = DECODE;
				end
			end
			DECODE: begin
				pc_mux_o = ctrl_pkg::PC_JUMP;
				if (instr_valid_i) begin
					if (special_req_i) begin
						state_d = FLUSH;
						halt_if = 1'b1;
					end else if (branch_set_i || jump_set_i) begin
						pc_set_o = 1'b1;
					end
					// hold fetch while a stalled instruction blocks the interrupt.
					if (irq_take_i && stall_i) begin
						halt_if = 1'b1;
					end
				end
				if (!stall_i && !special_req_i && irq_take_i) begin
					state_d  = IRQ_TAKEN;
					halt_if  = 1'b1;
					flush_id = 1'b1;
				end
			end
			IRQ_TAKEN: begin
				pc_mux_o     = ctrl_pkg::PC_EXC;
				exc_pc_mux_o = ctrl_pkg::EXC_PC_IRQ;
				if (irq_take_i) begin
					pc_set_o         = 1'b1;
					csr_o.save_if    = 1'b1;
					csr_o.save_cause = 1'b1;
					csr_o.cause      = irq_cause_i;
					if (irq_cause_i.irq && (irq_cause_i.code == `CTRL_IRQ_NM)) begin
						nmi_mode_d = 1'b1;
					end
				end
				state_d = DECODE;
			end
			FLUSH: begin
				halt_if  = 1'b1;
				flush_id = 1'b1;
				state_d  = DECODE;
				if (req_i.exc) begin
					pc_set_o         = 1'b1;
					pc_mux_o         = ctrl_pkg::PC_EXC;
					exc_pc_mux_o     = ctrl_pkg::EXC_PC_EXC;
					csr_o.save_id    = 1'b1;
					csr_o.save_cause = 1'b1;
					csr_o.cause      = req_i.cause;
					csr_o.mtval      = req_i.tval;
				end else if (req_i.mret) begin
					pc_set_o           = 1'b1;
					pc_mux_o           = ctrl_pkg::PC_ERET;
					csr_o.restore_mret = 1'b1;
					nmi_mode_d         = 1'b0;
				end else if (req_i.wfi) begin
					state_d = WAIT_SLEEP;
				end
			end
			WAIT_SLEEP: begin
				ctrl_busy_o = 1'b0;
				instr_req_o = 1'b0;
				halt_if     = 1'b1;
				flush_id    = 1'b1;
				state_d     = SLEEP;
			end
			SLEEP: begin
				instr_req_o = 1'b0;
				halt_if     = 1'b1;
				flush_id    = 1'b1;
				if (irq_wake_i) begin
					state_d = FIRST_FETCH;
				end else begin
					ctrl_busy_o = 1'b0;
				end
			end
			default: begin
				instr_req_o = 1'b0;
				state_d     = RESET;
			end
		endcase
	end

	assign flush_state_o       = (state_q == FLUSH);
	assign nmi_mode_o          = nmi_mode_q;
	assign id_in_ready_o       = ~stall_i & ~halt_if;
	assign instr_valid_clear_o = ~(stall_i | halt_if) | flush_id;

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state_q    <= RESET;
			nmi_mode_q <= 1'b0;
		end else begin
			state_q    <= state_d;
			nmi_mode_q <= nmi_mode_d;
		end
	end

	// ------------------------------
	// the captured request has to account for every entry into FLUSH.
	a_flush_has_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
		(state_q == FLUSH) |-> (req_i.exc || req_i.mret || req_i.wfi));

	a_irq_cause_flag: assert property (@(posedge clk_i) disable iff (!rst_ni)
		irq_take_i |-> irq_cause_i.irq);

endmodule

//--- src/ctrl_top.sv
module ctrl_top (
	input  logic                   clk_i,
	input  logic                   rst_ni,
	input  logic                   fetch_enable_i,
	input  ctrl_pkg::id_info_t     id_i,
	input  ctrl_pkg::lsu_err_t     lsu_i,
	input  ctrl_pkg::irq_vec_t     irqs_i,
	input  logic                   irq_nm_i,
	input  logic                   csr_mstatus_mie_i,
	input  ctrl_pkg::priv_lvl_e    priv_mode_i,
	input  logic                   csr_mstatus_tw_i,
	input  logic                   stall_i,
	input  logic                   branch_set_i,
	input  logic                   jump_set_i,
	output logic                   nmi_mode_o,
	output logic                   ctrl_busy_o,
	output logic                   instr_req_o,
	output logic                   id_in_ready_o,
	output logic                   instr_valid_clear_o,
	output logic                   pc_set_o,
	output ctrl_pkg::pc_sel_e      pc_mux_o,
	output ctrl_pkg::exc_pc_sel_e  exc_pc_mux_o,
	output ctrl_pkg::csr_ctrl_t    csr_o
);

	ctrl_pkg::exc_req_t    req;
	ctrl_pkg::exc_cause_t  irq_cause;
	logic                  special_req;
	logic                  irq_take;
	logic                  irq_wake;
	logic                  flush_state;

	ctrl_irq_arbiter u_irq_arbiter (
		.irqs_i            (irqs_i),
		.irq_nm_i          (irq_nm_i),
		.csr_mstatus_mie_i (csr_mstatus_mie_i),
		.nmi_mode_i        (nmi_mode_o),
		.irq_take_o        (irq_take),
		.irq_wake_o        (irq_wake),
		.irq_cause_o       (irq_cause)
	);

	ctrl_exc_capture u_exc_capture (
		.clk_i            (clk_i),
		.rst_ni           (rst_ni),
		.id_i             (id_i),
		.lsu_i            (lsu_i),
		.priv_mode_i      (priv_mode_i),
		.csr_mstatus_tw_i (csr_mstatus_tw_i),
		.flush_state_i    (flush_state),
		.special_req_o    (special_req),
		.req_o            (req)
	);

	ctrl_fsm u_fsm (
		.clk_i               (clk_i),
		.rst_ni              (rst_ni),
		.fetch_enable_i      (fetch_enable_i),
		.instr_valid_i       (id_i.valid),
		.stall_i             (stall_i),
		.branch_set_i        (branch_set_i),
		.jump_set_i          (jump_set_i),
		.special_req_i       (special_req),
		.req_i               (req),
		.irq_take_i          (irq_take),
		.irq_cause_i         (irq_cause),
		.irq_wake_i          (irq_wake),
		.flush_state_o       (flush_state),
		.nmi_mode_o          (nmi_mode_o),
		.ctrl_busy_o         (ctrl_busy_o),
		.instr_req_o         (instr_req_o),
		.id_in_ready_o       (id_in_ready_o),
		.instr_valid_clear_o (instr_valid_clear_o),
		.pc_set_o            (pc_set_o),
		.pc_mux_o            (pc_mux_o),
		.exc_pc_mux_o        (exc_pc_mux_o),
		.csr_o               (csr_o)
	);

endmodule

//--- bench/ctrl_tb.sv
module ctrl_tb;
	timeunit 1ns;
	timeprecision 100ps;

	typedef struct {
		string                 name;
		ctrl_pkg::id_info_t    id;
		ctrl_pkg::lsu_err_t    lsu;
		ctrl_pkg::priv_lvl_e   priv;
		logic                  tw;
		ctrl_pkg::exc_cause_t  cause;
		logic [31:0]           tval;
	} exc_row_t;

	typedef struct {
		string                 name;
		ctrl_pkg::irq_vec_t    lines;
		ctrl_pkg::exc_cause_t  cause;
	} irq_row_t;

	logic                   clk_i;
	logic                   rst_ni;
	logic                   fetch_enable_i;
	ctrl_pkg::id_info_t     id_i;
	ctrl_pkg::lsu_err_t     lsu_i;
	ctrl_pkg::irq_vec_t     irqs_i;
	logic                   irq_nm_i;
	logic                   csr_mstatus_mie_i;
	ctrl_pkg::priv_lvl_e    priv_mode_i;
	logic                   csr_mstatus_tw_i;
	logic                   stall_i;
	logic                   branch_set_i;
	logic                   jump_set_i;
	logic                   nmi_mode_o;
	logic                   ctrl_busy_o;
	logic                   instr_req_o;
	logic                   id_in_ready_o;
	logic                   instr_valid_clear_o;
	logic                   pc_set_o;
	ctrl_pkg::pc_sel_e      pc_mux_o;
	ctrl_pkg::exc_pc_sel_e  exc_pc_mux_o;
	ctrl_pkg::csr_ctrl_t    csr_o;

	exc_row_t  exc_rows[$];
	irq_row_t  irq_rows[$];
	int        errors;
	int        test_base;
	int        tests_run;
	int        tests_failed;
	bit        found;

	ctrl_top dut_i (.*);

	initial begin
		clk_i = 1'b0;
		forever #4 clk_i = ~clk_i;
	end

	// ------------------------------
	task automatic step();
		@(posedge clk_i);
		#1;
	endtask

	task automatic settle();
		@(negedge clk_i);
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("ERR t=%0t %s expected=%b got=%b", $time, name, exp, got);
			errors++;
		end
	endtask

	task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERR t=%0t %s expected=%h got=%h", $time, name, exp, got);
			errors++;
		end
	endtask

	task automatic check_cause(input string name, input ctrl_pkg::exc_cause_t got,
			input ctrl_pkg::exc_cause_t exp);
		if (got !== exp) begin
			$display("ERR t=%0t %s expected=%h got=%h", $time, name, exp, got);
			errors++;
		end
	endtask

	task automatic check_pc_sel(input string name, input ctrl_pkg::pc_sel_e got,
			input ctrl_pkg::pc_sel_e exp);
		if (got !== exp) begin
			$display("ERR t=%0t %s expected=%s got=%s", $time, name, exp.name(), got.name());
			errors++;
		end
	endtask

	task automatic check_exc_pc(input string name, input ctrl_pkg::exc_pc_sel_e got,
			input ctrl_pkg::exc_pc_sel_e exp);
		if (got !== exp) begin
			$display("ERR t=%0t %s expected=%s got=%s", $time, name, exp.name(), got.name());
			errors++;
		end
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (errors == test_base) begin
			$display("PASS %s", name);
		end else begin
			tests_failed++;
			$display("FAIL %s", name);
		end
		test_base = errors;
	endtask

	// ------------------------------
	task automatic wait_irq_entry(input int limit, output bit hit);
		hit = 1'b0;
		for (int i = 0; i < limit && !hit; i++) begin
			settle();
			if (pc_set_o && pc_mux_o == ctrl_pkg::PC_EXC && exc_pc_mux_o == ctrl_pkg::EXC_PC_IRQ)
				hit = 1'b1;
		end
		if (!hit) begin
			$display("timeout: no interrupt entry within %0d cycles at %0t", limit, $time);
			errors++;
		end
	endtask

	task automatic wait_busy(input logic level, input int limit);
		bit hit;
		hit = 1'b0;
		for (int i = 0; i < limit && !hit; i++) begin
			settle();
			if (ctrl_busy_o === level)
				hit = 1'b1;
		end
		if (!hit) begin
			$display("timeout: ctrl_busy_o did not reach %b within %0d cycles", level, limit);
			errors++;
		end
	endtask

	task automatic wait_ready(input int limit);
		bit hit;
		hit = 1'b0;
		for (int i = 0; i < limit && !hit; i++) begin
			settle();
			if (id_in_ready_o === 1'b1)
				hit = 1'b1;
		end
		if (!hit) begin
			$display("timeout: id_in_ready_o stayed low for %0d cycles", limit);
			errors++;
		end
	endtask

	// ------------------------------
	function automatic ctrl_pkg::id_info_t rand_id();
		ctrl_pkg::id_info_t id;
		id         = '0;
		id.valid   = 1'b1;
		id.instr   = $urandom();
		id.instr_c = 16'($urandom());
		id.pc      = $urandom() & 32'hffff_fffe;
		return id;
	endfunction

	task automatic add_exc_row(input string name, input ctrl_pkg::id_info_t id,
			input ctrl_pkg::lsu_err_t lsu, input ctrl_pkg::priv_lvl_e priv, input logic tw,
			input ctrl_pkg::exc_cause_t cause, input logic [31:0] tval);
		exc_row_t row;
		row.name  = name;
		row.id    = id;
		row.lsu   = lsu;
		row.priv  = priv;
		row.tw    = tw;
		row.cause = cause;
		row.tval  = tval;
		exc_rows.push_back(row);
	endtask

	task automatic build_tables();
		ctrl_pkg::id_info_t  id;
		ctrl_pkg::lsu_err_t  lsu;
		id = rand_id();
		id.fetch_err = 1'b1;
		add_exc_row("fetch error", id, '0, ctrl_pkg::PRIV_LVL_M, 1'b0, 6'h01, id.pc);
		id = rand_id();
		id.illegal = 1'b1;
		add_exc_row("illegal", id, '0, ctrl_pkg::PRIV_LVL_M, 1'b0, 6'h02, id.instr);
		id = rand_id();
		id.illegal       = 1'b1;
		id.is_compressed = 1'b1;
		add_exc_row("illegal compressed", id, '0, ctrl_pkg::PRIV_LVL_M, 1'b0, 6'h02,
			{16'h0, id.instr_c});
		id = rand_id();
		id.ecall = 1'b1;
		add_exc_row("ecall user", id, '0, ctrl_pkg::PRIV_LVL_U, 1'b0, 6'h08, '0);
		add_exc_row("ecall machine", id, '0, ctrl_pkg::PRIV_LVL_M, 1'b0, 6'h0b, '0);
		id = rand_id();
		id.ebreak = 1'b1;
		add_exc_row("ebreak", id, '0, ctrl_pkg::PRIV_LVL_M, 1'b0, 6'h03, '0);
		lsu = '0;
		lsu.load_err = 1'b1;
		lsu.addr     = $urandom();
		add_exc_row("load fault", rand_id(), lsu, ctrl_pkg::PRIV_LVL_M, 1'b0, 6'h05, lsu.addr);
		lsu = '0;
		lsu.store_err = 1'b1;
		lsu.addr      = $urandom();
		add_exc_row("store fault", rand_id(), lsu, ctrl_pkg::PRIV_LVL_M, 1'b0, 6'h07, lsu.addr);
		// machine-only instructions seen from user mode.
		id = rand_id();
		id.mret = 1'b1;
		add_exc_row("mret in user mode", id, '0, ctrl_pkg::PRIV_LVL_U, 1'b0, 6'h02, id.instr);
		id = rand_id();
		id.wfi = 1'b1;
		add_exc_row("wfi in user mode with tw", id, '0, ctrl_pkg::PRIV_LVL_U, 1'b1, 6'h02,
			id.instr);
		// lines are software, timer, external, then fast 14 down to 0.
		irq_rows.push_back(irq_row_t'{"fast 14 over all lower", {3'b111, 15'h4009}, 6'h3e});
		irq_rows.push_back(irq_row_t'{"fast 0 over external", {3'b001, 15'h0001}, 6'h30});
		irq_rows.push_back(irq_row_t'{"fast 7 over timer", {3'b010, 15'h0080}, 6'h37});
		irq_rows.push_back(irq_row_t'{"external over software", {3'b111, 15'h0000}, 6'h2b});
		irq_rows.push_back(irq_row_t'{"software over timer", {3'b110, 15'h0000}, 6'h23});
		irq_rows.push_back(irq_row_t'{"timer alone", {3'b010, 15'h0000}, 6'h27});
	endtask

	// ------------------------------
	task automatic run_exc_row(input exc_row_t row);
		step();
		id_i             = row.id;
		lsu_i            = row.lsu;
		priv_mode_i      = row.priv;
		csr_mstatus_tw_i = row.tw;
		step();
		id_i             = '0;
		lsu_i            = '0;
		priv_mode_i      = ctrl_pkg::PRIV_LVL_M;
		csr_mstatus_tw_i = 1'b0;
		settle();
		check_bit("pc_set_o", pc_set_o, 1'b1);
		check_pc_sel("pc_mux_o", pc_mux_o, ctrl_pkg::PC_EXC);
		check_exc_pc("exc_pc_mux_o", exc_pc_mux_o, ctrl_pkg::EXC_PC_EXC);
		check_bit("csr_o.save_id", csr_o.save_id, 1'b1);
		check_bit("csr_o.save_cause", csr_o.save_cause, 1'b1);
		check_cause("csr_o.cause", csr_o.cause, row.cause);
		check_word("csr_o.mtval", csr_o.mtval, row.tval);
		check_bit("id_in_ready_o", id_in_ready_o, 1'b0);
		check_bit("instr_valid_clear_o", instr_valid_clear_o, 1'b1);
		end_test(row.name);
	endtask

	task automatic run_irq_row(input irq_row_t row);
		bit hit;
		step();
		irqs_i = row.lines;
		wait_irq_entry(8, hit);
		if (hit) begin
			check_cause("csr_o.cause", csr_o.cause, row.cause);
			check_bit("csr_o.save_if", csr_o.save_if, 1'b1);
			check_bit("csr_o.save_cause", csr_o.save_cause, 1'b1);
		end
		step();
		irqs_i = '0;
		end_test(row.name);
	endtask

	task automatic run_mret();
		step();
		id_i        = '0;
		id_i.valid  = 1'b1;
		id_i.mret   = 1'b1;
		priv_mode_i = ctrl_pkg::PRIV_LVL_M;
		step();
		id_i = '0;
		settle();
		check_bit("pc_set_o", pc_set_o, 1'b1);
		check_pc_sel("pc_mux_o", pc_mux_o, ctrl_pkg::PC_ERET);
		check_bit("csr_o.restore_mret", csr_o.restore_mret, 1'b1);
	endtask

	initial begin
		void'($urandom(32'he812));
		errors            = 0;
		test_base         = 0;
		tests_run         = 0;
		tests_failed      = 0;
		rst_ni            = 1'b0;
		fetch_enable_i    = 1'b0;
		id_i              = '0;
		lsu_i             = '0;
		irqs_i            = '0;
		irq_nm_i          = 1'b0;
		csr_mstatus_mie_i = 1'b1;
		priv_mode_i       = ctrl_pkg::PRIV_LVL_M;
		csr_mstatus_tw_i  = 1'b0;
		stall_i           = 1'b0;
		branch_set_i      = 1'b0;
		jump_set_i        = 1'b0;
		build_tables();

		repeat (16) @(posedge clk_i);
		#1;
		rst_ni = 1'b1;
		settle();
		check_bit("instr_req_o", instr_req_o, 1'b0);
		check_bit("pc_set_o", pc_set_o, 1'b1);
		check_pc_sel("pc_mux_o", pc_mux_o, ctrl_pkg::PC_BOOT);
		check_bit("nmi_mode_o", nmi_mode_o, 1'b0);
		step();
		fetch_enable_i = 1'b1;
		step();
		settle();
		check_bit("pc_set_o", pc_set_o, 1'b1);
		check_bit("instr_req_o", instr_req_o, 1'b1);
		check_pc_sel("pc_mux_o", pc_mux_o, ctrl_pkg::PC_BOOT);
		step();
		wait_ready(8);
		step();
		end_test("boot");

		// back-pressure, then a taken branch in decode.
		stall_i = 1'b1;
		settle();
		check_bit("id_in_ready_o", id_in_ready_o, 1'b0);
		check_bit("instr_valid_clear_o", instr_valid_clear_o, 1'b0);
		step();
		stall_i      = 1'b0;
		id_i.valid   = 1'b1;
		branch_set_i = 1'b1;
		settle();
		check_bit("pc_set_o", pc_set_o, 1'b1);
		check_pc_sel("pc_mux_o", pc_mux_o, ctrl_pkg::PC_JUMP);
		check_bit("instr_valid_clear_o", instr_valid_clear_o, 1'b1);
		step();
		id_i         = '0;
		branch_set_i = 1'b0;
		end_test("stall and branch");

		foreach (exc_rows[i])
			run_exc_row(exc_rows[i]);
		run_mret();
		end_test("mret in machine mode");
		foreach (irq_rows[i])
			run_irq_row(irq_rows[i]);

		// the NMI outranks the external line raised with it.
		step();
		irq_nm_i        = 1'b1;
		irqs_i.external = 1'b1;
		wait_irq_entry(8, found);
		if (found)
			check_cause("csr_o.cause", csr_o.cause, 6'h3f);
		step();
		irq_nm_i = 1'b0;
		settle();
		check_bit("nmi_mode_o", nmi_mode_o, 1'b1);
		for (int i = 0; i < 10; i++) begin
			settle();
			check_bit("pc_set_o", pc_set_o, 1'b0);
		end
		step();
		irqs_i = '0;
		run_mret();
		step();
		settle();
		check_bit("nmi_mode_o", nmi_mode_o, 1'b0);
		end_test("nmi mode");

		step();
		id_i       = '0;
		id_i.valid = 1'b1;
		id_i.wfi   = 1'b1;
		step();
		id_i = '0;
		wait_busy(1'b0, 8);
		step();
		settle();
		check_bit("ctrl_busy_o", ctrl_busy_o, 1'b0);
		step();
		irqs_i.timer = 1'b1;
		wait_busy(1'b1, 8);
		wait_irq_entry(8, found);
		if (found)
			check_cause("csr_o.cause", csr_o.cause, 6'h27);
		step();
		irqs_i = '0;
		end_test("sleep and timer wake-up");

		$display("tests run: %0d, tests failed: %0d, check errors: %0d",
			tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

//--- sources.f
+incdir+src
src/ctrl_pkg.sv
src/ctrl_irq_arbiter.sv
src/ctrl_exc_capture.sv
src/ctrl_fsm.sv
src/ctrl_top.sv
bench/ctrl_tb.sv
